// ==== axis_top.f ====
common/mm_cfg_pkg.sv
common/mm_ctrl_pkg.sv
rtl/axis_fifo.sv
mm_core/block_mac.sv
mm_core/mm_engine.sv
rtl/axis_mm_ctrl.sv
rtl/axis_top.sv
sim/axis_top_asserts.sv
sim/axis_top_tb.sv

// ==== common/mm_cfg_pkg.sv ====
// Q8.8 elements in 2x2 blocks packed four lanes per 64-bit word; FIFO counts limited to 16 bits
package mm_cfg_pkg;

    localparam int WIDTH       = 16;                    // Element width
    localparam int FRAC_WIDTH  = 8;                     // Q8.8 fraction bits
    localparam int BLOCK_SIZE  = 2;                     // Block edge
    localparam int LANES       = BLOCK_SIZE * BLOCK_SIZE; // Elements per word
    localparam int WORD_WIDTH  = LANES * WIDTH;         // Stream word
    localparam int ACC_WIDTH   = 40;                    // MAC accumulator
    localparam int COUNT_WIDTH = 16;                    // FIFO occupancy port

    typedef logic signed [WIDTH-1:0]     elem_t;
    typedef logic signed [ACC_WIDTH-1:0] acc_t;

    localparam acc_t SAT_MAX = acc_t'(32767);           // Clip limits after rescale
    localparam acc_t SAT_MIN = acc_t'(-32768);

    // Number of 2x2 blocks covering an outer x inner matrix
    function automatic int blocks(input int outer, input int inner);
        return (outer / BLOCK_SIZE) * (inner / BLOCK_SIZE);
    endfunction

    // Index width for n entries, never below one bit
    function automatic int addr_w(input int n);
        return (n > 1) ? $clog2(n) : 1;
    endfunction

    // Lane idx = i*2+j holds element (i, j)
    function automatic elem_t lane(input logic [WORD_WIDTH-1:0] word, input int idx);
        return elem_t'(word[idx*WIDTH +: WIDTH]);
    endfunction

endpackage

// ==== common/mm_ctrl_pkg.sv ====
// Frame controller states; one frame is handled at a time, in the order listed
package mm_ctrl_pkg;

    typedef enum logic [2:0] {
        ST_IDLE,    // Wait for a full frame in both FIFOs
        ST_LOAD,    // Pop FIFOs into engine buffers
        ST_START,   // One-cycle engine start
        ST_WAIT,    // Engine busy
        ST_DRAIN    // Push result blocks to output FIFO
    } ctrl_state_t;

endpackage

// ==== mm_core/block_mac.sv ====
// 2x2 block MAC, lane (i,j) sums a(i,k)*b(j,k); result floors by 8 bits and clips to 16 bits
`timescale 1ns/1ps

module block_mac (
    input  logic                              aclk,
    input  logic                              arst_n,
    input  logic                              clear,
    input  logic                              en,
    input  logic [mm_cfg_pkg::WORD_WIDTH-1:0] a_blk,
    input  logic [mm_cfg_pkg::WORD_WIDTH-1:0] b_blk,
    output logic [mm_cfg_pkg::WORD_WIDTH-1:0] c_blk
);
    import mm_cfg_pkg::*;

    acc_t acc [LANES];                                  // One accumulator per lane
    acc_t sum [LANES];                                  // This cycle's block product

    always_comb
    begin
        for (int i = 0; i < BLOCK_SIZE; i++)
            for (int j = 0; j < BLOCK_SIZE; j++)
            begin
                sum[i*BLOCK_SIZE+j] = '0;
                for (int k = 0; k < BLOCK_SIZE; k++)    // Row of a times row of b, W is transposed
                    sum[i*BLOCK_SIZE+j] += acc_t'(lane(a_blk, i*BLOCK_SIZE+k))
                                         * acc_t'(lane(b_blk, j*BLOCK_SIZE+k));
            end
    end

    always_ff @(posedge aclk or negedge arst_n)
    begin
        if (!arst_n)
            acc <= '{default: '0};
        else
            for (int l = 0; l < LANES; l++)
            begin
                if (clear && en)
                    acc[l] <= sum[l];                   // First inner block
                else if (clear)
                    acc[l] <= '0;
                else if (en)
                    acc[l] <= acc[l] + sum[l];
            end
    end

    always_comb
    begin
        acc_t sh;
        for (int l = 0; l < LANES; l++)
        begin
            sh = acc[l] >>> FRAC_WIDTH;                 // Floor rescale
            if (sh > SAT_MAX)
                sh = SAT_MAX;
            else if (sh < SAT_MIN)
                sh = SAT_MIN;
            c_blk[l*WIDTH +: WIDTH] = sh[WIDTH-1:0];
        end
    end

endmodule

// ==== mm_core/mm_engine.sv ====
// Block engine for C = I * W^T; done is a one-cycle pulse outputs*(INNER/2+1) cycles after start
`timescale 1ns/1ps

module mm_engine #(
    parameter int I_OUTER = 4,
    parameter int W_OUTER = 4,
    parameter int INNER   = 4
) (
    input  logic                                                              aclk,
    input  logic                                                              arst_n,
    input  logic                                                              i_wr,
    input  logic [mm_cfg_pkg::addr_w(mm_cfg_pkg::blocks(I_OUTER, INNER))-1:0]   i_addr,
    input  logic [mm_cfg_pkg::WORD_WIDTH-1:0]                                 i_data,
    input  logic                                                              w_wr,
    input  logic [mm_cfg_pkg::addr_w(mm_cfg_pkg::blocks(W_OUTER, INNER))-1:0]   w_addr,
    input  logic [mm_cfg_pkg::WORD_WIDTH-1:0]                                 w_data,
    input  logic                                                              start,
    output logic                                                              done,
    input  logic [mm_cfg_pkg::addr_w(mm_cfg_pkg::blocks(I_OUTER, W_OUTER))-1:0] o_addr,
    output logic [mm_cfg_pkg::WORD_WIDTH-1:0]                                 o_data
);
    import mm_cfg_pkg::*;

    localparam int I_BLKS = blocks(I_OUTER, INNER);
    localparam int W_BLKS = blocks(W_OUTER, INNER);
    localparam int O_BLKS = blocks(I_OUTER, W_OUTER);
    localparam int KB     = INNER / BLOCK_SIZE;         // Inner blocks per output
    localparam int RB     = I_OUTER / BLOCK_SIZE;       // Output block rows
    localparam int CB     = W_OUTER / BLOCK_SIZE;       // Output block columns

    logic [WORD_WIDTH-1:0] i_mem [I_BLKS];              // Row-major (row, inner)
    logic [WORD_WIDTH-1:0] w_mem [W_BLKS];              // Row-major (col, inner)
    logic [WORD_WIDTH-1:0] o_mem [O_BLKS];              // Row-major (row, col)

    logic [addr_w(RB)-1:0] br;
    logic [addr_w(CB)-1:0] bc;
    logic [addr_w(KB)-1:0] k;
    logic                  mac_ph;                      // Accumulating one block
    logic                  store_ph;                    // Writing c_blk
    logic                  last_k;
    logic                  last_col;
    logic                  last_row;
    logic [WORD_WIDTH-1:0] a_blk;
    logic [WORD_WIDTH-1:0] b_blk;
    logic [WORD_WIDTH-1:0] c_blk;

    assign last_k   = (k == KB - 1);
    assign last_col = (bc == CB - 1);
    assign last_row = (br == RB - 1);
    assign a_blk    = i_mem[br * KB + k];
    assign b_blk    = w_mem[bc * KB + k];
    assign done     = store_ph && last_row && last_col; // Same cycle as final store
    assign o_data   = o_mem[o_addr];                    // Async read for drain

    block_mac u_mac (
        .aclk   (aclk),
        .arst_n (arst_n),
        .clear  (mac_ph && (k == '0)),                  // New output block
        .en     (mac_ph),
        .a_blk  (a_blk),
        .b_blk  (b_blk),
        .c_blk  (c_blk)
    );

    always_ff @(posedge aclk)
    begin
        if (i_wr)
            i_mem[i_addr] <= i_data;
        if (w_wr)
            w_mem[w_addr] <= w_data;
        if (store_ph)
            o_mem[br * CB + bc] <= c_blk;
    end

    always_ff @(posedge aclk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            mac_ph   <= 1'b0;
            store_ph <= 1'b0;
            br       <= '0;
            bc       <= '0;
            k        <= '0;
        end
        else if (start)
        begin
            mac_ph   <= 1'b1;
            store_ph <= 1'b0;
            br       <= '0;
            bc       <= '0;
            k        <= '0;
        end
        else if (mac_ph)
        begin
            if (last_k)
            begin
                mac_ph   <= 1'b0;
                store_ph <= 1'b1;
                k        <= '0;
            end
            else
                k <= k + 1'b1;
        end
        else if (store_ph)
        begin
            store_ph <= 1'b0;
            mac_ph   <= !(last_row && last_col);        // Stop after last block
            if (last_col)
            begin
                bc <= '0;
                br <= br + 1'b1;
            end
            else
                bc <= bc + 1'b1;
        end
    end

endmodule

// ==== rtl/axis_fifo.sv ====
// Single clock, first word fall through, DEPTH below 2**16; tlast stored beside the data
`timescale 1ns/1ps

module axis_fifo #(
    parameter int DATA_WIDTH = 64,
    parameter int DEPTH      = 8
) (
    input  logic                                 aclk,
    input  logic                                 arst_n,
    input  logic [DATA_WIDTH-1:0]                s_tdata,
    input  logic                                 s_tvalid,
    input  logic                                 s_tlast,
    output logic                                 s_tready,
    output logic [DATA_WIDTH-1:0]                m_tdata,
    output logic                                 m_tvalid,
    output logic                                 m_tlast,
    input  logic                                 m_tready,
    output logic [mm_cfg_pkg::COUNT_WIDTH-1:0]   count
);
    import mm_cfg_pkg::*;

    localparam int AW = addr_w(DEPTH);

    logic [DATA_WIDTH:0] mem [DEPTH];                   // tlast in top bit
    logic [AW-1:0]       wr_ptr;
    logic [AW-1:0]       rd_ptr;
    logic                push;
    logic                pop;

    assign s_tready = (count < DEPTH);                  // Room left
    assign m_tvalid = (count != '0);                    // Head word present
    assign push     = s_tvalid && s_tready;
    assign pop      = m_tvalid && m_tready;

    assign {m_tlast, m_tdata} = mem[rd_ptr];            // Head read is combinational

    always_ff @(posedge aclk)
    begin
        if (push)
            mem[wr_ptr] <= {s_tlast, s_tdata};
    end

    always_ff @(posedge aclk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)                                   // Wrap at DEPTH, any size
                wr_ptr <= (wr_ptr == AW'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == AW'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
            count <= count + COUNT_WIDTH'(push) - COUNT_WIDTH'(pop); // Push and pop may meet
        end
    end

endmodule

// ==== rtl/axis_mm_ctrl.sv ====
// One frame in flight; waits for complete frames in both FIFOs, incoming tlast is not used
`timescale 1ns/1ps

module axis_mm_ctrl #(
    parameter int I_OUTER = 4,
    parameter int W_OUTER = 4,
    parameter int INNER   = 4
) (
    input  logic                                                              aclk,
    input  logic                                                              arst_n,
    input  logic [mm_cfg_pkg::COUNT_WIDTH-1:0]                                i_count,
    input  logic [mm_cfg_pkg::WORD_WIDTH-1:0]                                 i_tdata,
    output logic                                                              i_pop,
    input  logic [mm_cfg_pkg::COUNT_WIDTH-1:0]                                w_count,
    input  logic [mm_cfg_pkg::WORD_WIDTH-1:0]                                 w_tdata,
    output logic                                                              w_pop,
    output logic                                                              i_wr,
    output logic [mm_cfg_pkg::addr_w(mm_cfg_pkg::blocks(I_OUTER, INNER))-1:0]   i_addr,
    output logic [mm_cfg_pkg::WORD_WIDTH-1:0]                                 i_data,
    output logic                                                              w_wr,
    output logic [mm_cfg_pkg::addr_w(mm_cfg_pkg::blocks(W_OUTER, INNER))-1:0]   w_addr,
    output logic [mm_cfg_pkg::WORD_WIDTH-1:0]                                 w_data,
    output logic                                                              start,
    input  logic                                                              done,
    output logic [mm_cfg_pkg::addr_w(mm_cfg_pkg::blocks(I_OUTER, W_OUTER))-1:0] o_addr,
    input  logic [mm_cfg_pkg::WORD_WIDTH-1:0]                                 o_data,
    output logic [mm_cfg_pkg::WORD_WIDTH-1:0]                                 o_tdata,
    output logic                                                              o_tvalid,
    output logic                                                              o_tlast,
    input  logic                                                              o_tready
);
    import mm_cfg_pkg::*;
    import mm_ctrl_pkg::*;

    localparam int I_BLKS = blocks(I_OUTER, INNER);
    localparam int W_BLKS = blocks(W_OUTER, INNER);
    localparam int O_BLKS = blocks(I_OUTER, W_OUTER);
    localparam int I_AW   = addr_w(I_BLKS);
    localparam int W_AW   = addr_w(W_BLKS);
    localparam int O_AW   = addr_w(O_BLKS);

    ctrl_state_t              state;
    ctrl_state_t              state_nxt;
    logic [addr_w(I_BLKS+1)-1:0] i_cnt;                 // Reaches I_BLKS when done
    logic [addr_w(W_BLKS+1)-1:0] w_cnt;
    logic [O_AW-1:0]          o_cnt;
    logic                     frame_rdy;
    logic                     load_end;

    assign frame_rdy = (i_count >= I_BLKS) && (w_count >= W_BLKS);
    assign i_pop     = (state == ST_LOAD) && (i_cnt < I_BLKS);
    assign w_pop     = (state == ST_LOAD) && (w_cnt < W_BLKS);
    assign load_end  = (i_cnt >= I_BLKS - 1) && (w_cnt >= W_BLKS - 1); // Last pop cycle

    assign i_wr     = i_pop;                            // FIFO head goes straight to buffer
    assign i_addr   = i_cnt[I_AW-1:0];
    assign i_data   = i_tdata;
    assign w_wr     = w_pop;
    assign w_addr   = w_cnt[W_AW-1:0];
    assign w_data   = w_tdata;
    assign start    = (state == ST_START);
    assign o_tvalid = (state == ST_DRAIN);
    assign o_addr   = o_cnt;
    assign o_tdata  = o_data;
    assign o_tlast  = o_tvalid && (o_cnt == O_AW'(O_BLKS - 1)); // Frame end

    always_comb
    begin
        state_nxt = state;
        case (state)
            ST_IDLE:  if (frame_rdy) state_nxt = ST_LOAD;
            ST_LOAD:  if (load_end) state_nxt = ST_START;
            ST_START: state_nxt = ST_WAIT;
            ST_WAIT:  if (done) state_nxt = ST_DRAIN;
            ST_DRAIN: if (o_tready && o_tlast) state_nxt = ST_IDLE;
            default:  state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge aclk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state <= ST_IDLE;
            i_cnt <= '0;
            w_cnt <= '0;
            o_cnt <= '0;
        end
        else
        begin
            state <= state_nxt;
            if (state == ST_IDLE)                       // Rearm load counters
            begin
                i_cnt <= '0;
                w_cnt <= '0;
            end
            else
            begin
                if (i_pop)
                    i_cnt <= i_cnt + 1'b1;
                if (w_pop)
                    w_cnt <= w_cnt + 1'b1;
            end
            if (state == ST_WAIT)
                o_cnt <= '0;
            else if (o_tvalid && o_tready)              // Advance only when taken
                o_cnt <= o_cnt + 1'b1;
        end
    end

endmodule

// ==== rtl/axis_top.sv ====
// AXI-Stream matmul top, dimensions fixed at build time and multiples of 2; no tkeep or tuser
`timescale 1ns/1ps

module axis_top #(
    parameter int I_OUTER    = 4,
    parameter int W_OUTER    = 4,
    parameter int INNER      = 4,
    parameter int FIFO_DEPTH = 2 * mm_cfg_pkg::blocks((I_OUTER > W_OUTER) ? I_OUTER : W_OUTER,
                                                      INNER)
) (
    input  logic                              aclk,
    input  logic                              arst_n,
    input  logic [mm_cfg_pkg::WORD_WIDTH-1:0] s_axis_i_tdata,
    input  logic                              s_axis_i_tvalid,
    input  logic                              s_axis_i_tlast,
    output logic                              s_axis_i_tready,
    input  logic [mm_cfg_pkg::WORD_WIDTH-1:0] s_axis_w_tdata,
    input  logic                              s_axis_w_tvalid,
    input  logic                              s_axis_w_tlast,
    output logic                              s_axis_w_tready,
    output logic [mm_cfg_pkg::WORD_WIDTH-1:0] m_axis_tdata,
    output logic                              m_axis_tvalid,
    output logic                              m_axis_tlast,
    input  logic                              m_axis_tready
);
    import mm_cfg_pkg::*;

    localparam int I_AW = addr_w(blocks(I_OUTER, INNER));
    localparam int W_AW = addr_w(blocks(W_OUTER, INNER));
    localparam int O_AW = addr_w(blocks(I_OUTER, W_OUTER));

    logic [COUNT_WIDTH-1:0] i_count, w_count;
    logic [WORD_WIDTH-1:0]  i_tdata, w_tdata, i_data, w_data, o_data, o_tdata;
    logic                   i_pop, w_pop, i_wr, w_wr, start, done;
    logic [I_AW-1:0]        i_addr;
    logic [W_AW-1:0]        w_addr;
    logic [O_AW-1:0]        o_addr;
    logic                   o_tvalid, o_tlast, o_tready;

    axis_fifo #(.DATA_WIDTH(WORD_WIDTH), .DEPTH(FIFO_DEPTH)) u_fifo_i (
        .aclk(aclk), .arst_n(arst_n),
        .s_tdata(s_axis_i_tdata), .s_tvalid(s_axis_i_tvalid), .s_tlast(s_axis_i_tlast),
        .s_tready(s_axis_i_tready),
        .m_tdata(i_tdata), .m_tvalid(), .m_tlast(), .m_tready(i_pop), // tlast dropped
        .count(i_count)
    );

    axis_fifo #(.DATA_WIDTH(WORD_WIDTH), .DEPTH(FIFO_DEPTH)) u_fifo_w (
        .aclk(aclk), .arst_n(arst_n),
        .s_tdata(s_axis_w_tdata), .s_tvalid(s_axis_w_tvalid), .s_tlast(s_axis_w_tlast),
        .s_tready(s_axis_w_tready),
        .m_tdata(w_tdata), .m_tvalid(), .m_tlast(), .m_tready(w_pop),
        .count(w_count)
    );

    axis_mm_ctrl #(.I_OUTER(I_OUTER), .W_OUTER(W_OUTER), .INNER(INNER)) u_ctrl (
        .aclk(aclk), .arst_n(arst_n),
        .i_count(i_count), .i_tdata(i_tdata), .i_pop(i_pop),
        .w_count(w_count), .w_tdata(w_tdata), .w_pop(w_pop),
        .i_wr(i_wr), .i_addr(i_addr), .i_data(i_data),
        .w_wr(w_wr), .w_addr(w_addr), .w_data(w_data),
        .start(start), .done(done), .o_addr(o_addr), .o_data(o_data),
        .o_tdata(o_tdata), .o_tvalid(o_tvalid), .o_tlast(o_tlast), .o_tready(o_tready)
    );

    mm_engine #(.I_OUTER(I_OUTER), .W_OUTER(W_OUTER), .INNER(INNER)) u_engine (
        .aclk(aclk), .arst_n(arst_n),
        .i_wr(i_wr), .i_addr(i_addr), .i_data(i_data),
        .w_wr(w_wr), .w_addr(w_addr), .w_data(w_data),
        .start(start), .done(done), .o_addr(o_addr), .o_data(o_data)
    );

    axis_fifo #(.DATA_WIDTH(WORD_WIDTH), .DEPTH(FIFO_DEPTH)) u_fifo_o (
        .aclk(aclk), .arst_n(arst_n),
        .s_tdata(o_tdata), .s_tvalid(o_tvalid), .s_tlast(o_tlast), .s_tready(o_tready),
        .m_tdata(m_axis_tdata), .m_tvalid(m_axis_tvalid), .m_tlast(m_axis_tlast),
        .m_tready(m_axis_tready),
        .count()                                        // Drain relies on s_tready only
    );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run, then look for the pass line in sim.log
cd "$(dirname "$0")" &&
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert -Wno-fatal --top-module axis_top_tb \
    -f axis_top.f > build.log 2>&1 &&
./obj_dir/Vaxis_top_tb > sim.log 2>&1
grep -q "Testbench passed" sim.log && echo "Simulation PASS" ||
    { echo "Simulation FAIL, see build.log and sim.log"; exit 1; }

// ==== sim/axis_top_asserts.sv ====
// Output stream handshake checks, bound to axis_top below; all but the reset rule skip reset
`timescale 1ns/1ps

module axis_top_asserts (
    input logic                              aclk,
    input logic                              arst_n,
    input logic [mm_cfg_pkg::WORD_WIDTH-1:0] m_axis_tdata,
    input logic                              m_axis_tvalid,
    input logic                              m_axis_tlast,
    input logic                              m_axis_tready
);

    m_hold_stable: assert property (@(posedge aclk) disable iff (!arst_n)
        m_axis_tvalid && !m_axis_tready |=>
            m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tlast))
        else $error("m_axis word changed or withdrawn while stalled");

    last_with_valid: assert property (@(posedge aclk) disable iff (!arst_n)
        m_axis_tlast |-> m_axis_tvalid)
        else $error("m_axis_tlast high without m_axis_tvalid");

    // Reset must hold the output stream idle
    no_valid_in_reset: assert property (@(posedge aclk) !arst_n |-> !m_axis_tvalid)
        else $error("m_axis_tvalid high during reset");

endmodule

bind axis_top axis_top_asserts u_asserts (.*);

// ==== sim/axis_top_tb.sv ====
// Runs axis_top at 4x4x4 only; expected blocks come from a local Q8.8 model, seed 78
`timescale 1ns/1ps

module axis_top_tb;
    import mm_cfg_pkg::*;

    localparam int I_OUTER      = 4;
    localparam int W_OUTER      = 4;
    localparam int INNER        = 4;
    localparam int KB           = INNER / 2;            // Inner blocks
    localparam int CB           = W_OUTER / 2;          // Output block columns
    localparam int I_BLKS       = (I_OUTER / 2) * KB;
    localparam int W_BLKS       = (W_OUTER / 2) * KB;
    localparam int O_BLKS       = (I_OUTER / 2) * CB;
    localparam int FRAMES       = 5;                    // Tests 2 to 4 one each, test 5 two
    localparam int FRAME_BUDGET = 800;                  // Gaps and random stalls included
    localparam int MAX_CYCLES   = FRAMES * FRAME_BUDGET;

    logic                  aclk;
    logic                  arst_n;
    logic [WORD_WIDTH-1:0] s_axis_i_tdata;
    logic                  s_axis_i_tvalid;
    logic                  s_axis_i_tlast;
    logic                  s_axis_i_tready;
    logic [WORD_WIDTH-1:0] s_axis_w_tdata;
    logic                  s_axis_w_tvalid;
    logic                  s_axis_w_tlast;
    logic                  s_axis_w_tready;
    logic [WORD_WIDTH-1:0] m_axis_tdata;
    logic                  m_axis_tvalid;
    logic                  m_axis_tlast;
    logic                  m_axis_tready;

    int                    i_mat [I_OUTER][INNER];      // Raw Q8.8 values
    int                    w_mat [W_OUTER][INNER];
    logic [WORD_WIDTH:0]   exp_q [$];                   // {tlast, tdata}
    logic [31:0]           rng_state    = 32'd78;
    int                    error_count  = 0;
    int                    check_count  = 0;
    int                    cycle_count  = 0;
    logic                  random_ready = 1'b0;
    logic                  hold_output  = 1'b0;         // Output must stay idle

    axis_top #(.I_OUTER(I_OUTER), .W_OUTER(W_OUTER), .INNER(INNER)) dut (
        .aclk            (aclk),
        .arst_n          (arst_n),
        .s_axis_i_tdata  (s_axis_i_tdata),
        .s_axis_i_tvalid (s_axis_i_tvalid),
        .s_axis_i_tlast  (s_axis_i_tlast),
        .s_axis_i_tready (s_axis_i_tready),
        .s_axis_w_tdata  (s_axis_w_tdata),
        .s_axis_w_tvalid (s_axis_w_tvalid),
        .s_axis_w_tlast  (s_axis_w_tlast),
        .s_axis_w_tready (s_axis_w_tready),
        .m_axis_tdata    (m_axis_tdata),
        .m_axis_tvalid   (m_axis_tvalid),
        .m_axis_tlast    (m_axis_tlast),
        .m_axis_tready   (m_axis_tready)
    );

    initial
    begin
        aclk = 1'b0;
        forever #5 aclk = ~aclk;                        // 10 ns period
    end

    function automatic logic [31:0] next_rand();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    // Range -4.0 to 4.0, sums never clip
    function automatic int small_elem();
        logic [31:0] r;
        r = next_rand();
        return int'($signed(r[10:0]));
    endfunction

    function automatic logic [WORD_WIDTH-1:0] pack_i(input int n);
        logic [WORD_WIDTH-1:0] word;
        for (int i = 0; i < 2; i++)
            for (int j = 0; j < 2; j++)                 // Block (row, inner) row-major
                word[(i*2+j)*16 +: 16] = 16'(i_mat[2*(n/KB)+i][2*(n%KB)+j]);
        return word;
    endfunction

    function automatic logic [WORD_WIDTH-1:0] pack_w(input int n);
        logic [WORD_WIDTH-1:0] word;
        for (int i = 0; i < 2; i++)
            for (int j = 0; j < 2; j++)                 // Block (col, inner) row-major
                word[(i*2+j)*16 +: 16] = 16'(w_mat[2*(n/KB)+i][2*(n%KB)+j]);
        return word;
    endfunction

    // Output block n of C = I * W^T, floored by 8 bits and clipped
    function automatic logic [WORD_WIDTH-1:0] ref_block(input int n);
        logic [WORD_WIDTH-1:0] word;
        longint                sum;
        for (int i = 0; i < 2; i++)
            for (int j = 0; j < 2; j++)
            begin
                sum = 0;
                for (int k = 0; k < INNER; k++)
                    sum += longint'(i_mat[2*(n/CB)+i][k]) * longint'(w_mat[2*(n%CB)+j][k]);
                sum = sum >>> 8;
                if (sum > 32767)
                    sum = 32767;
                else if (sum < -32768)
                    sum = -32768;
                word[(i*2+j)*16 +: 16] = 16'(sum);
            end
        return word;
    endfunction

    task automatic random_frame();
        for (int r = 0; r < I_OUTER; r++)
            for (int k = 0; k < INNER; k++)
                i_mat[r][k] = small_elem();
        for (int c = 0; c < W_OUTER; c++)
            for (int k = 0; k < INNER; k++)
                w_mat[c][k] = small_elem();
    endtask

    task automatic queue_expected();
        for (int n = 0; n < O_BLKS; n++)
            exp_q.push_back({n == O_BLKS - 1, ref_block(n)});
    endtask

    task automatic check_value(input string name, input logic [WORD_WIDTH-1:0] got,
                               input logic [WORD_WIDTH-1:0] exp);
        check_count++;
        if (got !== exp)
        begin
            $display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
            error_count++;
        end
    endtask

    // Called on a falling edge; gaps of 0 to max_gap-1 idle cycles
    task automatic send_i(input int max_gap);
        int gap;
        for (int n = 0; n < I_BLKS; n++)
        begin
            gap = (max_gap > 0) ? int'(next_rand() % max_gap) : 0;
            s_axis_i_tvalid = 1'b0;
            repeat (gap) @(negedge aclk);
            s_axis_i_tdata  = pack_i(n);
            s_axis_i_tlast  = (n == I_BLKS - 1);
            s_axis_i_tvalid = 1'b1;
            while (!s_axis_i_tready) @(negedge aclk);   // Ready moves on rising edges only
            @(negedge aclk);
        end
        s_axis_i_tvalid = 1'b0;
        s_axis_i_tlast  = 1'b0;
    endtask

    task automatic send_w(input int max_gap);
        int gap;
        for (int n = 0; n < W_BLKS; n++)
        begin
            gap = (max_gap > 0) ? int'(next_rand() % max_gap) : 0;
            s_axis_w_tvalid = 1'b0;
            repeat (gap) @(negedge aclk);
            s_axis_w_tdata  = pack_w(n);
            s_axis_w_tlast  = (n == W_BLKS - 1);
            s_axis_w_tvalid = 1'b1;
            while (!s_axis_w_tready) @(negedge aclk);
            @(negedge aclk);
        end
        s_axis_w_tvalid = 1'b0;
        s_axis_w_tlast  = 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) @(negedge aclk);
        repeat (4) @(negedge aclk);                     // Room for a stray extra block
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (error_count == errs_before)
            $display("test %s: ok", name);
        else
            $display("test %s: FAILED with %0d errors", name, error_count - errs_before);
    endtask

    // Output side, ready and compare on falling edges
    always @(negedge aclk)
    begin
        logic [WORD_WIDTH:0] exp_word;
        logic [31:0]         r;
        if (arst_n)
        begin
            if (random_ready)
            begin
                r = next_rand();
                m_axis_tready = r[0];
            end
            else
                m_axis_tready = 1'b1;
            if (m_axis_tvalid && hold_output)
            begin
                $display("Output valid at %0t before both frames were complete", $time);
                error_count++;
            end
            if (m_axis_tvalid && m_axis_tready)         // Taken at the next rising edge
            begin
                if (exp_q.size() == 0)
                begin
                    $display("Unexpected output block at %0t, none was due", $time);
                    error_count++;
                end
                else
                begin
                    exp_word = exp_q.pop_front();
                    check_value("m_axis_tdata", m_axis_tdata, exp_word[WORD_WIDTH-1:0]);
                    check_value("m_axis_tlast", WORD_WIDTH'(m_axis_tlast),
                                WORD_WIDTH'(exp_word[WORD_WIDTH]));
                end
            end
        end
    end

    always @(posedge aclk)
    begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES)
        begin
            $display("Timeout after %0d cycles with %0d output blocks still due",
                     MAX_CYCLES, exp_q.size());
            $display("Testbench failed");
            $finish;
        end
    end

    initial
    begin
        int errs;
        arst_n          = 1'b0;
        s_axis_i_tdata  = '0;
        s_axis_i_tvalid = 1'b0;
        s_axis_i_tlast  = 1'b0;
        s_axis_w_tdata  = '0;
        s_axis_w_tvalid = 1'b0;
        s_axis_w_tlast  = 1'b0;
        m_axis_tready   = 1'b0;
        repeat (8) @(negedge aclk);
        arst_n = 1'b1;
        @(negedge aclk);

        errs = error_count;                             // Idle state after reset
        check_value("m_axis_tvalid", WORD_WIDTH'(m_axis_tvalid), '0);
        check_value("s_axis_i_tready", WORD_WIDTH'(s_axis_i_tready), WORD_WIDTH'(1));
        check_value("s_axis_w_tready", WORD_WIDTH'(s_axis_w_tready), WORD_WIDTH'(1));
        report_test("reset state", errs);

        errs = error_count;
        random_frame();
        queue_expected();
        fork
            send_i(0);
            send_w(0);
        join
        wait_drain();
        report_test("random frame", errs);

        errs = error_count;                             // Rows 0,1 clip high, rows 2,3 low
        for (int r = 0; r < I_OUTER; r++)
            for (int k = 0; k < INNER; k++)
                i_mat[r][k] = (r < 2) ? 32767 : -32768;
        for (int c = 0; c < W_OUTER; c++)
            for (int k = 0; k < INNER; k++)
                w_mat[c][k] = (c % 2 == 0) ? 32767 : small_elem();
        queue_expected();
        fork
            send_i(0);
            send_w(0);
        join
        wait_drain();
        report_test("saturation", errs);

        errs = error_count;
        random_frame();
        queue_expected();
        hold_output = 1'b1;
        send_w(0);
        send_i(4);
        hold_output = 1'b0;
        wait_drain();
        report_test("uneven arrival", errs);

        errs = error_count;
        random_ready = 1'b1;
        repeat (2)
        begin
            random_frame();
            queue_expected();
            fork
                send_i(0);
                send_w(0);
            join
        end
        wait_drain();
        random_ready = 1'b0;
        report_test("back-pressure", errs);

        $display("all tests done: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule
